//--- common/xbus_pkg.sv
// xbus package with bus widths, the address map and the state encodings.
package xbus_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // bus widths.
   typedef logic [21:0] bus_addr_t;   // 22-bit word address.
   typedef logic [31:0] bus_data_t;   // one bus word.
   typedef logic [1:0]  reg_idx_t;    // register select inside a slave.

   // ~~~~~~~~~~~~~~~~~~~~
   // address map, octal as on the processor side.
   localparam bus_addr_t DRAM_LIMIT = 22'o16777777;   // last dram word.
   localparam bus_addr_t DMA_BASE   = 22'o17377770;   // four dma registers.
   localparam bus_addr_t TIMER_BASE = 22'o17764000;   // four timer registers.

   // read value when no slave drives the bus.
   localparam bus_data_t BUS_FLOAT = 32'hffff_ffff;

   // ~~~~~~~~~~~~~~~~~~~~
   // decoder output.
   typedef enum logic [1:0] {
      region_none,
      region_dram,
      region_dma,
      region_timer
   } region_t;

   // arbiter states.
   typedef enum logic [1:0] {
      bus_idle,
      bus_req,
      bus_wait,
      bus_slave
   } arb_state_t;

   // dma engine states.
   typedef enum logic [1:0] {
      dma_idle,
      dma_read,
      dma_write
   } dma_state_t;

endpackage

//--- common/xbus_if.sv
// xbus interface, one word transfer per req/ack handshake.
`timescale 1ns/1ps

interface xbus_if
   import xbus_pkg::*;
   ();

   bus_addr_t addr;    // word address.
   bus_data_t wdata;   // write data, master to slave.
   bus_data_t rdata;   // read data, slave to master.
   logic      req;     // held until ack.
   logic      write;
   logic      ack;     // one cycle per transfer.

   modport master (
      output addr,
      output wdata,
      output req,
      output write,
      input  rdata,
      input  ack
   );

   modport slave (
      input  addr,
      input  wdata,
      input  req,
      input  write,
      output rdata,
      output ack
   );

endinterface

//--- rtl/xbus_ram.sv
// dram word memory, single port with a registered one-cycle ack.
`timescale 1ns/1ps

module xbus_ram
   import xbus_pkg::*;
   #(
   parameter int DRAM_ADDR_BITS = 10
   )
   (
   input  logic  mclk,
   input  logic  reset,
   xbus_if.slave bus
   );

   localparam int DEPTH = 1 << DRAM_ADDR_BITS;

   bus_data_t                 mem [DEPTH];
   logic [DRAM_ADDR_BITS-1:0] index;
   logic                      ack_q;
   bus_data_t                 rdata_q;
   logic                      access;

   // upper address bits alias.
   assign index  = bus.addr[DRAM_ADDR_BITS-1:0];
   assign access = bus.req && !ack_q;   // once per transfer.

   always_ff @(posedge mclk)
   begin
      if (reset)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   always_ff @(posedge mclk)
   begin
      if (access)
      begin
         if (bus.write)
            mem[index] <= bus.wdata;
         else
            rdata_q <= mem[index];
      end
   end

   assign bus.ack   = ack_q;
   assign bus.rdata = rdata_q;

endmodule

//--- rtl/xbus_dma.sv
// dma engine, copies a block of dram words and raises an interrupt when done.
`timescale 1ns/1ps

module xbus_dma
   import xbus_pkg::*;
   (
   input  logic   mclk,
   input  logic   reset,
   xbus_if.slave  regs,
   xbus_if.master mem,
   output logic   interrupt
   );

   dma_state_t state;
   bus_addr_t  src;
   bus_addr_t  dst;
   bus_addr_t  count;       // words left.
   bus_data_t  buffer;      // word between read and write.
   logic       done;
   logic       busy;
   logic       ack_q;
   bus_data_t  rdata_q;
   logic       reg_access;
   reg_idx_t   idx;

   assign idx        = regs.addr[1:0];
   assign reg_access = regs.req && !ack_q;
   assign busy       = (state != dma_idle);

   // ~~~~~~~~~~~~~~~~~~~~
   // register slave.
   always_ff @(posedge mclk)
   begin
      if (reset)
         ack_q <= 1'b0;
      else
         ack_q <= reg_access;
   end

   always_ff @(posedge mclk)
   begin
      if (reg_access && !regs.write)
      begin
         case (idx)
            2'd0:    rdata_q <= bus_data_t'(src);
            2'd1:    rdata_q <= bus_data_t'(dst);
            2'd2:    rdata_q <= bus_data_t'(count);
            default: rdata_q <= {30'b0, done, busy};   // status.
         endcase
      end
   end

   assign regs.ack   = ack_q;
   assign regs.rdata = rdata_q;

   // ~~~~~~~~~~~~~~~~~~~~
   // copy engine.
   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         state <= dma_idle;
         done  <= 1'b0;
      end
      else if (state == dma_idle)
      begin
         if (reg_access && regs.write)
         begin
            case (idx)
               2'd0: src   <= regs.wdata[21:0];
               2'd1: dst   <= regs.wdata[21:0];
               2'd2: count <= regs.wdata[21:0];
               default:
               begin
                  if (regs.wdata[1])
                     done <= 1'b0;
                  if (regs.wdata[0])
                  begin
                     done  <= (count == '0);   // empty block finishes at once.
                     state <= (count == '0) ? dma_idle : dma_read;
                  end
               end
            endcase
         end
      end
      else if (state == dma_read)
      begin
         if (mem.ack)
         begin
            buffer <= mem.rdata;
            state  <= dma_write;
         end
      end
      else if (mem.ack)
      begin
         src   <= src + 1'b1;
         dst   <= dst + 1'b1;
         count <= count - 1'b1;
         if (count == bus_addr_t'(1))
         begin
            done  <= 1'b1;
            state <= dma_idle;
         end
         else
            state <= dma_read;
      end
   end

   // dram master, req held through cpu priority.
   assign mem.req   = busy;
   assign mem.write = (state == dma_write);
   assign mem.addr  = (state == dma_write) ? dst : src;
   assign mem.wdata = buffer;

   assign interrupt = done;

endmodule

//--- rtl/xbus_timer.sv
// interval timer, free-running count with compare match and interrupt enable.
`timescale 1ns/1ps

module xbus_timer
   import xbus_pkg::*;
   (
   input  logic  mclk,
   input  logic  reset,
   xbus_if.slave bus,
   output logic  interrupt
   );

   bus_data_t count;
   bus_data_t compare;
   logic      match;
   logic      irq_enable;
   logic      ack_q;
   bus_data_t rdata_q;
   logic      access;
   reg_idx_t  idx;

   assign idx    = bus.addr[1:0];
   assign access = bus.req && !ack_q;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack_q      <= 1'b0;
         count      <= '0;
         compare    <= '1;      // far from the count after reset.
         match      <= 1'b0;
         irq_enable <= 1'b0;
      end
      else
      begin
         ack_q <= access;
         if (access && bus.write && idx == 2'd0)
            count <= bus.wdata;   // load.
         else
            count <= count + 1'b1;
         if (access && bus.write && idx == 2'd1)
            compare <= bus.wdata;
         if (access && bus.write && idx == 2'd3)
            irq_enable <= bus.wdata[0];
         if (count == compare)
            match <= 1'b1;        // set beats clear.
         else if (access && bus.write && idx == 2'd2 && bus.wdata[0])
            match <= 1'b0;
      end
   end

   always_ff @(posedge mclk)
   begin
      if (access && !bus.write)
      begin
         case (idx)
            2'd0:    rdata_q <= count;
            2'd1:    rdata_q <= compare;
            2'd2:    rdata_q <= {31'b0, match};
            default: rdata_q <= {31'b0, irq_enable};
         endcase
      end
   end

   assign bus.ack   = ack_q;
   assign bus.rdata = rdata_q;
   assign interrupt = match & irq_enable;

endmodule

//--- busint/bus_arbiter.sv
// bus arbiter, cpu address decode and dram sharing between cpu and dma.
`timescale 1ns/1ps

module bus_arbiter
   import xbus_pkg::*;
   (
   input  logic   mclk,
   input  logic   reset,
   xbus_if.slave  cpu,
   xbus_if.slave  dma_mem,
   xbus_if.master dram,
   xbus_if.master dma_reg,
   xbus_if.master timer,
   output logic   load
   );

   region_t    region;
   arb_state_t state;
   arb_state_t next_state;
   logic       cpu_active;   // cpu request forwarded to a slave.
   logic       dma_owner;    // dma holds the dram.
   logic       cpu_ack;
   bus_data_t  read_data;
   bus_data_t  busout_q;

   // ~~~~~~~~~~~~~~~~~~~~
   // address decode.
   always_comb
   begin
      if (cpu.addr <= DRAM_LIMIT)
         region = region_dram;
      else if (cpu.addr[21:2] == DMA_BASE[21:2])
         region = region_dma;
      else if (cpu.addr[21:2] == TIMER_BASE[21:2])
         region = region_timer;
      else
         region = region_none;   // never acked, cpu times out.
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // arbitration, cpu wins from idle.
   always_comb
   begin
      next_state = state;
      case (state)
         bus_idle:
         begin
            if (cpu.req)
               next_state = bus_req;
            else if (dma_mem.req)
               next_state = bus_slave;
         end
         bus_req:
         begin
            if (cpu_ack)
               next_state = bus_wait;
            else if (!cpu.req)
               next_state = bus_idle;
         end
         bus_wait:   if (!cpu.req) next_state = bus_idle;   // cpu releases req.
         bus_slave:  if (dram.ack) next_state = bus_idle;   // one dma word done.
         default:    next_state = bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         state <= bus_idle;
      else
         state <= next_state;
   end

   assign cpu_active = (state == bus_req) && cpu.req;
   assign dma_owner  = (state == bus_slave);

   // dram port, dma or cpu.
   assign dram.addr  = dma_owner ? dma_mem.addr  : cpu.addr;
   assign dram.wdata = dma_owner ? dma_mem.wdata : cpu.wdata;
   assign dram.write = dma_owner ? dma_mem.write : cpu.write;
   assign dram.req   = dma_owner ? dma_mem.req   : cpu_active && (region == region_dram);

   assign dma_mem.rdata = dram.rdata;
   assign dma_mem.ack   = dma_owner && dram.ack;

   // register slaves only ever see the cpu.
   assign dma_reg.addr  = cpu.addr;
   assign dma_reg.wdata = cpu.wdata;
   assign dma_reg.write = cpu.write;
   assign dma_reg.req   = cpu_active && (region == region_dma);

   assign timer.addr  = cpu.addr;
   assign timer.wdata = cpu.wdata;
   assign timer.write = cpu.write;
   assign timer.req   = cpu_active && (region == region_timer);

   // ~~~~~~~~~~~~~~~~~~~~
   // ack and read data back to the cpu.
   always_comb
   begin
      case (region)
         region_dram:  read_data = dram.rdata;
         region_dma:   read_data = dma_reg.rdata;
         region_timer: read_data = timer.rdata;
         default:      read_data = BUS_FLOAT;
      endcase
   end

   assign cpu_ack = (state == bus_req) &&
                    ((region == region_dram  && dram.ack) ||
                     (region == region_dma   && dma_reg.ack) ||
                     (region == region_timer && timer.ack));
   assign cpu.ack = cpu_ack;

   always_ff @(posedge mclk)
   begin
      if (cpu_ack && !cpu.write)
         busout_q <= read_data;   // held until the next read.
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         load <= 1'b0;
      else
         load <= cpu_ack && !cpu.write;   // cycle after read completion.
   end

   assign cpu.rdata = busout_q;

endmodule

//--- busint/busint.sv
// busint top, cpu bus port onto dram, dma engine and interval timer.
`timescale 1ns/1ps

module busint
   import xbus_pkg::*;
   #(
   parameter int DRAM_ADDR_BITS = 10
   )
   (
   input  logic      mclk,
   input  logic      reset,
   input  bus_addr_t addr,
   input  bus_data_t busin,
   output bus_data_t busout,
   input  logic      req,
   input  logic      write,
   output logic      ack,
   output logic      load,
   output logic      interrupt
   );

   logic dma_interrupt;
   logic timer_interrupt;

   // ~~~~~~~~~~~~~~~~~~~~
   // bus instances.
   xbus_if cpu_bus ();
   xbus_if dram_bus ();
   xbus_if dma_mem_bus ();
   xbus_if dma_reg_bus ();
   xbus_if timer_bus ();

   // cpu pins onto the cpu bus.
   assign cpu_bus.addr  = addr;
   assign cpu_bus.wdata = busin;
   assign cpu_bus.req   = req;
   assign cpu_bus.write = write;
   assign busout        = cpu_bus.rdata;   // registered in the arbiter.
   assign ack           = cpu_bus.ack;

   // ~~~~~~~~~~~~~~~~~~~~
   // blocks.
   bus_arbiter arbiter (
      .mclk    (mclk),
      .reset   (reset),
      .cpu     (cpu_bus.slave),
      .dma_mem (dma_mem_bus.slave),
      .dram    (dram_bus.master),
      .dma_reg (dma_reg_bus.master),
      .timer   (timer_bus.master),
      .load    (load)
   );

   xbus_ram #(
      .DRAM_ADDR_BITS (DRAM_ADDR_BITS)
   ) dram (
      .mclk  (mclk),
      .reset (reset),
      .bus   (dram_bus.slave)
   );

   xbus_dma dma (
      .mclk      (mclk),
      .reset     (reset),
      .regs      (dma_reg_bus.slave),
      .mem       (dma_mem_bus.master),
      .interrupt (dma_interrupt)
   );

   xbus_timer timer (
      .mclk      (mclk),
      .reset     (reset),
      .bus       (timer_bus.slave),
      .interrupt (timer_interrupt)
   );

   assign interrupt = dma_interrupt | timer_interrupt;

endmodule

//--- tb/busint_sva.sv
// busint protocol assertions on the cpu port, bound to the top level.
`timescale 1ns/1ps

module busint_sva
   (
   input logic mclk,
   input logic reset,
   input logic req,
   input logic write,
   input logic ack,
   input logic load,
   input logic interrupt
   );

   int failures = 0;   // assertion failures so far.

   // ack only answers a pending request.
   ack_needs_req: assert property (@(posedge mclk) disable iff (reset)
      ack |-> $past(req))
      else
      begin
         failures++;
         $error("ack without a request in the previous cycle");
      end

   load_after_read: assert property (@(posedge mclk) disable iff (reset)
      (req && ack && !write) |=> load)
      else
      begin
         failures++;
         $error("no load in the cycle after a read completed");
      end

   load_only_after_read: assert property (@(posedge mclk) disable iff (reset)
      load |-> $past(req && ack && !write))
      else
      begin
         failures++;
         $error("load without a read completion one cycle before");
      end

   // outputs quiet once reset has been seen.
   quiet_in_reset: assert property (@(posedge mclk)
      (reset && $past(reset)) |-> (!ack && !load && !interrupt))
      else
      begin
         failures++;
         $error("ack, load or interrupt high during reset");
      end

endmodule

bind busint busint_sva sva (
   .mclk      (mclk),
   .reset     (reset),
   .req       (req),
   .write     (write),
   .ack       (ack),
   .load      (load),
   .interrupt (interrupt)
);

//--- tb/busint_tb.sv
// busint testbench, directed tests of dram, dma and timer through the cpu port.
`timescale 1ns/1ps

module busint_tb
   import xbus_pkg::*;
   ();

   localparam int DRAM_BITS   = 10;
   localparam int ACK_TIMEOUT = 50;

   logic      mclk;
   logic      reset;
   bus_addr_t addr;
   bus_data_t busin;
   bus_data_t busout;
   logic      req;
   logic      write;
   logic      ack;
   logic      load;
   logic      interrupt;

   bus_data_t   model [1 << DRAM_BITS];   // expected dram contents.
   bus_addr_t   scatter [8];
   logic [15:0] lfsr_state;
   string       test_name;
   int          last_latency;             // cycles from req to ack.

   busint #(
      .DRAM_ADDR_BITS (DRAM_BITS)
   ) i_dut (
      .mclk      (mclk),
      .reset     (reset),
      .addr      (addr),
      .busin     (busin),
      .busout    (busout),
      .req       (req),
      .write     (write),
      .ack       (ack),
      .load      (load),
      .interrupt (interrupt)
   );

   always #5 mclk = ~mclk;

   // ~~~~~~~~~~~~~~~~~~~~
   // random data, x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic bus_data_t random_word(input int bits);
      bus_data_t w;
      int        i;
      w = '0;
      for (i = 0; i < bits; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         w = {w[30:0], lfsr_state[0]};   // one step per bit.
      end
      return w;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~
   // error handling.
   task automatic stop_on_error(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check(input string what, input bus_data_t expected, input bus_data_t actual);
      if (expected !== actual)
         stop_on_error($sformatf("Mismatch in test %s, %s: expected %h, actual %h",
                                 test_name, what, expected, actual));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // bus tasks.
   task automatic wait_for_ack();
      last_latency = 0;
      while (!ack && last_latency < ACK_TIMEOUT)
      begin
         @(posedge mclk);
         #1;
         last_latency++;
      end
      if (!ack)
         stop_on_error($sformatf("test %s: no ack within %0d cycles at address %o",
                                 test_name, ACK_TIMEOUT, addr));
   endtask

   task automatic bus_write(input bus_addr_t a, input bus_data_t d);
      @(posedge mclk);
      #1;
      addr  = a;
      busin = d;
      write = 1'b1;
      req   = 1'b1;
      wait_for_ack();
      @(posedge mclk);   // completing edge.
      #1;
      req   = 1'b0;
      write = 1'b0;
   endtask

   task automatic bus_read(input bus_addr_t a, output bus_data_t d);
      @(posedge mclk);
      #1;
      addr  = a;
      write = 1'b0;
      req   = 1'b1;
      wait_for_ack();
      @(posedge mclk);
      #1;
      check("load after read", 32'd1, bus_data_t'(load));
      d   = busout;   // load cycle.
      req = 1'b0;
   endtask

   task automatic probe_unmapped(input bus_addr_t a, input logic wr);
      int i;
      @(posedge mclk);
      #1;
      addr  = a;
      busin = 32'h5a5a_a5a5;
      write = wr;
      req   = 1'b1;
      for (i = 0; i < 8; i++)
      begin
         @(posedge mclk);
         #1;
         if (ack)
            stop_on_error($sformatf("test %s: unmapped address %o was acknowledged",
                                    test_name, a));
      end
      req   = 1'b0;   // give up like the cpu does.
      write = 1'b0;
   endtask

   task automatic dram_write(input bus_addr_t a, input bus_data_t d);
      model[a[DRAM_BITS-1:0]] = d;   // upper bits alias.
      bus_write(a, d);
   endtask

   task automatic dram_check(input bus_addr_t a, input string what);
      bus_data_t d;
      bus_read(a, d);
      check(what, model[a[DRAM_BITS-1:0]], d);
   endtask

   task automatic wait_for_interrupt(input int limit);
      int cycles;
      cycles = 0;
      while (!interrupt && cycles < limit)
      begin
         @(posedge mclk);
         #1;
         cycles++;
      end
      if (!interrupt)
         stop_on_error($sformatf("test %s: no interrupt within %0d cycles", test_name, limit));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // dma helpers.
   task automatic start_copy(input bus_addr_t src, input bus_addr_t dst, input int count);
      bus_write(DMA_BASE, bus_data_t'(src));
      bus_write(DMA_BASE + 22'd1, bus_data_t'(dst));
      bus_write(DMA_BASE + 22'd2, bus_data_t'(count));
      bus_write(DMA_BASE + 22'd3, 32'h1);   // go.
   endtask

   task automatic finish_copy(input bus_addr_t src, input bus_addr_t dst, input int count);
      bus_data_t status;
      bus_addr_t s;
      bus_addr_t d;
      int        i;
      wait_for_interrupt(20 * count + 100);
      bus_read(DMA_BASE + 22'd3, status);
      check("status after copy", 32'h2, status);   // done, not busy.
      for (i = 0; i < count; i++)
      begin
         s = src + bus_addr_t'(i);
         d = dst + bus_addr_t'(i);
         model[d[DRAM_BITS-1:0]] = model[s[DRAM_BITS-1:0]];
      end
      for (i = 0; i < count; i++)
         dram_check(dst + bus_addr_t'(i), "copied word");
      bus_write(DMA_BASE + 22'd3, 32'h2);   // clear done.
      check("interrupt after clear", 32'd0, bus_data_t'(interrupt));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // directed tests.
   task automatic test_dram();
      int i;
      test_name = "dram";
      check("ack after reset", 32'd0, bus_data_t'(ack));
      check("load after reset", 32'd0, bus_data_t'(load));
      check("interrupt after reset", 32'd0, bus_data_t'(interrupt));
      for (i = 0; i < 8; i++)
      begin
         scatter[i] = bus_addr_t'(random_word(21));   // stays below the register space.
         dram_write(scatter[i], random_word(32));
         check("write latency", 32'd2, bus_data_t'(last_latency));
      end
      for (i = 0; i < 8; i++)
      begin
         dram_check(scatter[i], "read data");
         check("read latency", 32'd2, bus_data_t'(last_latency));
      end
   endtask

   task automatic test_unmapped();
      test_name = "unmapped";
      probe_unmapped(22'o17000000, 1'b0);
      probe_unmapped(22'o17000000, 1'b1);
      dram_check(scatter[0], "read after unmapped access");
   endtask

   task automatic test_dma_copy();
      int i;
      test_name = "dma copy";
      for (i = 0; i < 16; i++)
         dram_write(22'h100 + bus_addr_t'(i), random_word(32));
      start_copy(22'h100, 22'h180, 16);
      finish_copy(22'h100, 22'h180, 16);
   endtask

   task automatic test_cpu_during_dma();
      int i;
      test_name = "cpu during dma";
      for (i = 0; i < 64; i++)
         dram_write(22'h200 + bus_addr_t'(i), random_word(32));
      start_copy(22'h200, 22'h280, 64);
      // unrelated area while the copy runs.
      for (i = 0; i < 8; i++)
         dram_write(22'h300 + bus_addr_t'(i), random_word(32));
      for (i = 0; i < 8; i++)
         dram_check(22'h300 + bus_addr_t'(i), "cpu data during copy");
      check("copy still running", 32'd0, bus_data_t'(interrupt));
      finish_copy(22'h200, 22'h280, 64);
   endtask

   task automatic test_timer();
      bus_data_t first;
      bus_data_t second;
      bus_data_t flag;
      test_name = "timer";
      check("interrupt before timer", 32'd0, bus_data_t'(interrupt));
      bus_read(TIMER_BASE, first);
      bus_read(TIMER_BASE, second);
      if (!(second > first))
         stop_on_error($sformatf("test %s: timer count did not increase (%0d then %0d)",
                                 test_name, first, second));
      bus_write(TIMER_BASE + 22'd1, second + 32'd40);
      bus_write(TIMER_BASE + 22'd3, 32'h1);   // enable.
      wait_for_interrupt(200);
      bus_read(TIMER_BASE + 22'd2, flag);
      check("match flag", 32'd1, flag);
      bus_write(TIMER_BASE + 22'd2, 32'h1);
      check("interrupt after match clear", 32'd0, bus_data_t'(interrupt));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      mclk         = 1'b0;
      reset        = 1'b1;
      addr         = '0;
      busin        = '0;
      req          = 1'b0;
      write        = 1'b0;
      lfsr_state   = 16'd31;
      last_latency = 0;
      test_name    = "reset";
      repeat (5) @(posedge mclk);
      #1;
      reset = 1'b0;

      test_dram();
      test_unmapped();
      test_dma_copy();
      test_cpu_during_dma();
      test_timer();

      if (i_dut.sva.failures == 0)
      begin
         $display("Test OK");
         $finish;
      end
      else
      begin
         $display("Test FAILED");
         $fatal(1, "%0d assertion failures", i_dut.sva.failures);
      end
   end

endmodule

//--- compile.f
common/xbus_pkg.sv
common/xbus_if.sv
rtl/xbus_ram.sv
rtl/xbus_dma.sv
rtl/xbus_timer.sv
busint/bus_arbiter.sv
busint/busint.sv
tb/busint_sva.sv
tb/busint_tb.sv

//--- Makefile
# Verilator build and run for the busint testbench.
VERILATOR  ?= verilator
TOP        := busint_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test OK
VFLAGS     := --binary --timing --assert -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

# pass only if the log holds the pass line.
run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
